// File: run.sh
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

// File: src.f
verilog/fetch_pkg.sv
verilog/instr_scan.sv
verilog/ras.sv
verilog/branch_predict.sv
verilog/pc_gen.sv
verilog/fetch_queue.sv
verilog/frontend.sv
verification/tb_clk_gen.sv
verification/imem_model.sv
verification/tb_frontend.sv

// File: verification/imem_model.sv
`timescale 1ns/10ps

module imem_model (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [fetch_pkg::ILEN-1:0] mem_i [256],
  input  fetch_pkg::imem_req_t       req_i,
  output fetch_pkg::imem_rsp_t       rsp_o
);

  import fetch_pkg::*;

  // one request in flight, frontend never issues more
  logic            pend_q;
  logic [VLEN-1:0] addr_q;
  logic [1:0]      wait_q;

  initial begin
    rsp_o = '0;
  end

  // ------------------------------
  // request side, sampled on the rising edge
  // ------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      addr_q <= '0;
      wait_q <= '0;
    end else if (req_i.kill) begin
      // killed request returns nothing
      pend_q <= 1'b0;
    end else if (rsp_o.valid) begin
      pend_q <= 1'b0;
    end else if (req_i.req && rsp_o.ready) begin
      pend_q <= 1'b1;
      addr_q <= req_i.vaddr;
      // latency of 1 to 3 cycles after acceptance
      wait_q <= 2'($urandom_range(0, 2));
    end else if (pend_q && wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  // response side, driven on the falling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rsp_o <= '0;
    end else begin
      // ready drops now and then
      rsp_o.ready <= ($urandom_range(0, 3) != 0);
      rsp_o.valid <= pend_q && (wait_q == 2'd0);
      rsp_o.vaddr <= addr_q;
      // 1 KiB image, higher addresses alias
      rsp_o.data  <= mem_i[addr_q[9:2]];
    end
  end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset held for 5 cycles, released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verification/tb_frontend.sv
`timescale 1ns/10ps

module tb_frontend;

  import fetch_pkg::*;

  localparam logic [VLEN-1:0] BOOT_ADDR  = 32'h080;
  localparam logic [VLEN-1:0] EPC_ADDR   = 32'h080;
  localparam logic [VLEN-1:0] TRAP_BASE  = 32'h300;
  localparam logic [VLEN-1:0] FIX_TARGET = 32'h0b0;
  localparam int              WAIT_LIMIT = 500;

  logic            clk;
  logic            rst_n;
  logic [VLEN-1:0] boot_addr;
  logic [VLEN-1:0] epc;
  logic [VLEN-1:0] trap_base;
  logic            eret;
  logic            ex_valid;
  logic            flush;
  logic            fetch_valid;
  logic            fetch_ready;
  logic            ext_redirect;
  resolve_t        resolved;
  imem_req_t       imem_req;
  imem_rsp_t       imem_rsp;
  fetch_entry_t    fetch_entry;
  logic [ILEN-1:0] image [256];

  // reference model state
  logic [VLEN-1:0] exp_pc;
  logic [VLEN-1:0] stack [2];
  int              stack_cnt;
  logic            resync;
  logic            boot_seen;
  logic            timed_out;
  int              delivered = 0;
  int              check_errors = 0;
  int              prop_errors = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  imem_model u_imem (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .mem_i  (image),
    .req_i  (imem_req),
    .rsp_o  (imem_rsp)
  );

  frontend u_dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .boot_addr_i        (boot_addr),
    .epc_i              (epc),
    .trap_vector_base_i (trap_base),
    .eret_i             (eret),
    .ex_valid_i         (ex_valid),
    .flush_i            (flush),
    .resolved_i         (resolved),
    .imem_req_o         (imem_req),
    .imem_rsp_i         (imem_rsp),
    .fetch_entry_o      (fetch_entry),
    .fetch_valid_o      (fetch_valid),
    .fetch_ready_i      (fetch_ready)
  );

  assign ext_redirect = flush | eret | ex_valid | (resolved.valid & resolved.mispredict);

  // ------------------------------
  // properties
  // ------------------------------
  // head of the queue holds while the consumer stalls
  hold_check: assert property (@(posedge clk) disable iff (!rst_n)
      (fetch_valid && !fetch_ready && !ext_redirect) |=> (fetch_valid && $stable(fetch_entry)))
    else begin
      prop_errors++;
      $display("Error %0t: entry not held under back-pressure", $time);
    end

  flush_check: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !fetch_valid)
    else begin
      prop_errors++;
      $display("Error %0t: queue still valid after flush", $time);
    end

  kill_check: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req.req |-> !imem_req.kill)
    else begin
      prop_errors++;
      $display("Error %0t: request raised together with kill", $time);
    end

  // op-imm word built from the address, never control flow
  function automatic logic [ILEN-1:0] fill_word(input logic [VLEN-1:0] addr);
    return {addr[24:0] ^ {18'h0, addr[31:25]}, 7'b0010011};
  endfunction

  function automatic void report_error(input string msg);
    check_errors++;
    $display("Error %0t: %s", $time, msg);
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic check_entry(input fetch_entry_t e);
    logic [ILEN-1:0] w;
    logic [VLEN-1:0] imm_b;
    logic [VLEN-1:0] imm_j;
    logic [VLEN-1:0] tgt;
    cf_t             cf_exp;
    w     = image[e.pc[9:2]];
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    if (resync) begin
      // after a flush the frontend resumes somewhere ahead on the straight path
      assert (e.pc >= exp_pc && e.pc <= exp_pc + VLEN'(4 * (QUEUE_DEPTH + 3)))
        else report_error($sformatf("pc %h after flush, expected from %h on", e.pc, exp_pc));
      resync = 1'b0;
    end else begin
      assert (e.pc == exp_pc)
        else report_error($sformatf("pc %h, expected %h", e.pc, exp_pc));
    end
    assert (e.instr == w)
      else report_error($sformatf("word %h at %h, expected %h", e.instr, e.pc, w));
    cf_exp = CF_NONE;
    tgt    = e.pc + VLEN'(INSTR_BYTES);
    if (w[6:0] == OPC_JAL) begin
      cf_exp = CF_JUMP;
      tgt    = e.pc + imm_j;
      // call links into ra
      if (w[11:7] == 5'd1) begin
        stack[1] = stack[0];
        stack[0] = e.pc + VLEN'(INSTR_BYTES);
        if (stack_cnt < 2) begin
          stack_cnt++;
        end
      end
    end else if (w[6:0] == OPC_BRANCH && imm_b[VLEN-1]) begin
      cf_exp = CF_BRANCH;
      tgt    = e.pc + imm_b;
    end else if (w[6:0] == OPC_JALR && w[11:7] == 5'd0 && w[19:15] == 5'd1) begin
      // only predicted with a link address on the stack
      if (stack_cnt > 0) begin
        cf_exp   = CF_RETURN;
        tgt      = stack[0];
        stack[0] = stack[1];
        stack_cnt--;
      end
    end
    assert (e.cf == cf_exp)
      else report_error($sformatf("cf %0d at %h, expected %0d", e.cf, e.pc, cf_exp));
    if (cf_exp != CF_NONE) begin
      assert (e.predict_addr == tgt)
        else report_error($sformatf("target %h at %h, expected %h", e.predict_addr, e.pc, tgt));
    end
    exp_pc = tgt;
    delivered++;
  endtask

  task automatic apply_redirect();
    if (flush) begin
      stack_cnt = 0;
    end
    resync = 1'b0;
    // trap beats eret beats mispredict
    if (ex_valid) begin
      exp_pc = trap_base;
    end else if (eret) begin
      exp_pc = epc;
    end else if (resolved.valid && resolved.mispredict) begin
      exp_pc = resolved.target;
    end else begin
      resync = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc    = BOOT_ADDR;
      stack_cnt = 0;
      resync    = 1'b0;
      boot_seen = 1'b0;
    end else begin
      if (imem_req.req && imem_rsp.ready && !boot_seen) begin
        boot_seen = 1'b1;
        assert (imem_req.vaddr == boot_addr)
          else report_error($sformatf("first request at %h, expected %h",
                                      imem_req.vaddr, boot_addr));
      end
      if (fetch_valid && fetch_ready) begin
        check_entry(fetch_entry);
      end
      if (ext_redirect) begin
        apply_redirect();
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  // one cycle pulse, consumer stalled so nothing transfers during the redirect
  task automatic pulse(input logic mis, input logic er, input logic ex, input logic fl);
    @(negedge clk);
    fetch_ready         = 1'b0;
    resolved.valid      = mis;
    resolved.mispredict = mis;
    resolved.target     = FIX_TARGET;
    eret                = er;
    ex_valid            = ex;
    flush               = fl;
    @(negedge clk);
    resolved    = '0;
    eret        = 1'b0;
    ex_valid    = 1'b0;
    flush       = 1'b0;
    fetch_ready = ($urandom_range(0, 3) != 0);
  endtask

  task automatic wait_entries(input int n);
    int target;
    int cycles;
    target = delivered + n;
    cycles = 0;
    while (delivered < target && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      fetch_ready = ($urandom_range(0, 3) != 0);
      cycles++;
    end
    if (delivered < target) begin
      $display("Timeout: fewer than %0d entries arrived within %0d cycles", n, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(32'hf3e9577f));
    boot_addr   = BOOT_ADDR;
    epc         = EPC_ADDR;
    trap_base   = TRAP_BASE;
    eret        = 1'b0;
    ex_valid    = 1'b0;
    flush       = 1'b0;
    resolved    = '0;
    fetch_ready = 1'b0;
    timed_out   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      image[i] = fill_word(VLEN'(i * 4));
    end
    // program from 0x080
    image[33] = 32'h040000ef;  // jal ra, 0x0c4
    image[34] = 32'h00000863;  // beq forward
    image[35] = 32'h00000013;
    image[36] = 32'h00008067;  // ret on empty stack
    image[37] = 32'h0100006f;  // jal x0, 0x0a4
    image[41] = 32'h00000013;
    image[42] = 32'hfe001ee3;  // bne back to 0x0a4, endless loop
    image[45] = 32'h00028067;  // jalr via x5, not predicted
    image[49] = 32'h00000013;
    image[50] = 32'h00008067;  // ret to 0x088
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
    for (int s = 0; s < 8 && !timed_out; s++) begin
      case (s)
        1: pulse(1'b1, 1'b0, 1'b0, 1'b0);
        2: pulse(1'b0, 1'b1, 1'b0, 1'b0);
        3: pulse(1'b0, 1'b0, 1'b1, 1'b0);
        4: pulse(1'b1, 1'b1, 1'b0, 1'b0);
        5: pulse(1'b1, 1'b1, 1'b1, 1'b0);
        6: pulse(1'b0, 1'b0, 1'b0, 1'b1);
        7: pulse(1'b1, 1'b1, 1'b1, 1'b1);
        default: ;
      endcase
      // program reruns need more entries than straight code
      wait_entries((s == 0) ? 24 : (s == 2 || s == 4) ? 16 : 8);
    end
    $display("check errors: %0d, property errors: %0d, timed out: %0d",
             check_errors, prop_errors, timed_out);
    if (timed_out || check_errors != 0 || prop_errors != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  end

endmodule

// File: verilog/branch_predict.sv
`timescale 1ns/10ps

module branch_predict (
  input  logic                       valid_i,
  input  logic [fetch_pkg::VLEN-1:0] pc_i,
  input  fetch_pkg::scan_t           scan_i,
  input  fetch_pkg::ras_entry_t      ras_top_i,
  output fetch_pkg::prediction_t     pred_o,
  output logic                       ras_push_o,
  output logic                       ras_pop_o,
  output logic [fetch_pkg::VLEN-1:0] ras_data_o
);

  import fetch_pkg::*;

  logic [VLEN-1:0] imm_target;

  // shared adder for jal and branch targets
  assign imm_target = pc_i + scan_i.imm;

  // link address pushed by a call
  assign ras_data_o = pc_i + VLEN'(INSTR_BYTES);

  // ------------------------------
  // static prediction
  // ------------------------------
  always_comb begin
    pred_o     = '0;
    pred_o.cf  = CF_NONE;
    ras_push_o = 1'b0;
    ras_pop_o  = 1'b0;
    if (valid_i) begin
      if (scan_i.is_jal) begin
        // direct jump, target known right away
        pred_o.taken  = 1'b1;
        pred_o.target = imm_target;
        pred_o.cf     = CF_JUMP;
      end else if (scan_i.is_branch) begin
        // backward taken, forward not taken
        if (scan_i.imm[VLEN-1]) begin
          pred_o.taken  = 1'b1;
          pred_o.target = imm_target;
          pred_o.cf     = CF_BRANCH;
        end
      end else if (scan_i.is_return) begin
        // empty stack means no guess, fall through
        if (ras_top_i.valid) begin
          pred_o.taken  = 1'b1;
          pred_o.target = ras_top_i.addr;
          pred_o.cf     = CF_RETURN;
          ras_pop_o     = 1'b1;
        end
      end
      // a call is always a jal, so it is also taken above
      if (scan_i.is_call) begin
        ras_push_o = 1'b1;
      end
    end
  end

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  // ------------------------------
  // widths and sizes
  // ------------------------------
  // virtual address width
  localparam int VLEN        = 32;
  // instruction width, no compressed support
  localparam int ILEN        = 32;
  // pc step per fetched word
  localparam int INSTR_BYTES = 4;
  // fetch queue entries
  localparam int QUEUE_DEPTH = 4;
  // return address stack entries
  localparam int RAS_DEPTH   = 2;
  // queue count must also hold the full value
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
  localparam int QPTR_W      = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  // ------------------------------
  // rv32i encodings
  // ------------------------------
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  // x1 is the link register
  localparam logic [4:0] REG_RA     = 5'd1;

  // control flow class handed to the decoder
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_RETURN
  } cf_t;

  // scanner result for one word
  typedef struct packed {
    logic            is_branch;
    logic            is_jal;
    logic            is_call;
    logic            is_return;
    logic [VLEN-1:0] imm;
  } scan_t;

  typedef struct packed {
    logic [VLEN-1:0] pc;
    logic [ILEN-1:0] instr;
    cf_t             cf;
    logic [VLEN-1:0] predict_addr;
  } fetch_entry_t;

  // instruction memory port
  typedef struct packed {
    logic            req;
    logic            kill;
    logic [VLEN-1:0] vaddr;
  } imem_req_t;

  typedef struct packed {
    logic            ready;
    logic            valid;
    logic [VLEN-1:0] vaddr;
    logic [ILEN-1:0] data;
  } imem_rsp_t;

  // branch resolution from execute
  typedef struct packed {
    logic            valid;
    logic            mispredict;
    logic [VLEN-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic            taken;
    logic [VLEN-1:0] target;
    cf_t             cf;
  } prediction_t;

  // top of the return address stack
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] addr;
  } ras_entry_t;

endpackage

// File: verilog/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue #(
  parameter type entry_t = logic
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         push_i,
  input  entry_t                       entry_i,
  output logic [fetch_pkg::QCNT_W-1:0] space_o,
  output entry_t                       entry_o,
  output logic                         valid_o,
  input  logic                         ready_i
);

  import fetch_pkg::*;

  entry_t            mem_q [QUEUE_DEPTH];
  logic [QPTR_W-1:0] rptr_q, wptr_q;
  logic [QCNT_W-1:0] count_q;
  logic              full;
  logic              do_push;
  logic              do_pop;

  // wrap at the last entry, depth need not be a power of two
  function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
    if (ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count_q == QCNT_W'(QUEUE_DEPTH));
  assign do_push = push_i & ~full;
  assign do_pop  = valid_o & ready_i;

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rptr_q];
  assign space_o = QCNT_W'(QUEUE_DEPTH) - count_q;

  // ------------------------------
  // pointers and count
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (do_pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      count_q <= count_q + QCNT_W'(do_push) - QCNT_W'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push && !clear_i) begin
      mem_q[wptr_q] <= entry_i;
    end
  end

endmodule

// File: verilog/frontend.sv
`timescale 1ns/10ps

module frontend (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [fetch_pkg::VLEN-1:0] boot_addr_i,
  input  logic [fetch_pkg::VLEN-1:0] epc_i,
  input  logic [fetch_pkg::VLEN-1:0] trap_vector_base_i,
  input  logic                       eret_i,
  input  logic                       ex_valid_i,
  input  logic                       flush_i,
  input  fetch_pkg::resolve_t        resolved_i,
  output fetch_pkg::imem_req_t       imem_req_o,
  input  fetch_pkg::imem_rsp_t       imem_rsp_i,
  output fetch_pkg::fetch_entry_t    fetch_entry_o,
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i
);

  import fetch_pkg::*;

  logic              word_valid;
  logic [VLEN-1:0]   word_pc;
  logic [ILEN-1:0]   word;
  logic              redirect;
  logic              push;
  logic [QCNT_W-1:0] queue_space;
  scan_t             scan;
  prediction_t       pred;
  ras_entry_t        ras_top;
  logic              ras_push;
  logic              ras_pop;
  logic [VLEN-1:0]   ras_data;
  fetch_entry_t      entry;

  // word survives unless an external redirect hits this cycle
  // a taken prediction still enters the queue
  assign push = word_valid & ~redirect;

  // ------------------------------
  // entry assembly
  // ------------------------------
  assign entry.pc           = word_pc;
  assign entry.instr        = word;
  assign entry.cf           = pred.cf;
  assign entry.predict_addr = pred.target;

  pc_gen i_pc_gen (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .boot_addr_i        (boot_addr_i),
    .epc_i              (epc_i),
    .trap_vector_base_i (trap_vector_base_i),
    .eret_i             (eret_i),
    .ex_valid_i         (ex_valid_i),
    .flush_i            (flush_i),
    .resolved_i         (resolved_i),
    .pred_i             (pred),
    .queue_space_i      (queue_space),
    .imem_req_o         (imem_req_o),
    .imem_rsp_i         (imem_rsp_i),
    .word_valid_o       (word_valid),
    .word_pc_o          (word_pc),
    .word_o             (word),
    .redirect_o         (redirect)
  );

  instr_scan i_instr_scan (
    .instr_i (word),
    .scan_o  (scan)
  );

  // prediction only on a word that is actually kept
  branch_predict i_branch_predict (
    .valid_i    (push),
    .pc_i       (word_pc),
    .scan_i     (scan),
    .ras_top_i  (ras_top),
    .pred_o     (pred),
    .ras_push_o (ras_push),
    .ras_pop_o  (ras_pop),
    .ras_data_o (ras_data)
  );

  ras i_ras (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .push_i  (ras_push),
    .pop_i   (ras_pop),
    .data_i  (ras_data),
    .top_o   (ras_top)
  );

  fetch_queue #(
    .entry_t (fetch_entry_t)
  ) i_fetch_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (redirect),
    .push_i  (push),
    .entry_i (entry),
    .space_o (queue_space),
    .entry_o (fetch_entry_o),
    .valid_o (fetch_valid_o),
    .ready_i (fetch_ready_i)
  );

endmodule

// File: verilog/instr_scan.sv
`timescale 1ns/10ps

module instr_scan (
  input  logic [fetch_pkg::ILEN-1:0] instr_i,
  output fetch_pkg::scan_t           scan_o
);

  import fetch_pkg::*;

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [VLEN-1:0] imm_b;
  logic [VLEN-1:0] imm_j;

  // standard rv32 field positions
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // ------------------------------
  // immediates
  // ------------------------------
  // b-type, bit 0 always zero
  assign imm_b = {{(VLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  // j-type, bit 0 always zero
  assign imm_j = {{(VLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ------------------------------
  // classification
  // ------------------------------
  always_comb begin
    scan_o = '0;
    // conditional branch
    scan_o.is_branch = (opcode == OPC_BRANCH);
    // direct jump, a call when it links into ra
    scan_o.is_jal    = (opcode == OPC_JAL);
    scan_o.is_call   = scan_o.is_jal && (rd == REG_RA);
    // jalr x0, 0(ra) style return
    // any other jalr has an unknown target and is left alone
    scan_o.is_return = (opcode == OPC_JALR) && (rd == 5'd0) && (rs1 == REG_RA);
    if (scan_o.is_jal) begin
      scan_o.imm = imm_j;
    end else if (scan_o.is_branch) begin
      scan_o.imm = imm_b;
    end
  end

endmodule

// File: verilog/pc_gen.sv
`timescale 1ns/10ps

module pc_gen (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [fetch_pkg::VLEN-1:0]   boot_addr_i,
  input  logic [fetch_pkg::VLEN-1:0]   epc_i,
  input  logic [fetch_pkg::VLEN-1:0]   trap_vector_base_i,
  input  logic                         eret_i,
  input  logic                         ex_valid_i,
  input  logic                         flush_i,
  input  fetch_pkg::resolve_t          resolved_i,
  input  fetch_pkg::prediction_t       pred_i,
  input  logic [fetch_pkg::QCNT_W-1:0] queue_space_i,
  output fetch_pkg::imem_req_t         imem_req_o,
  input  fetch_pkg::imem_rsp_t         imem_rsp_i,
  output logic                         word_valid_o,
  output logic [fetch_pkg::VLEN-1:0]   word_pc_o,
  output logic [fetch_pkg::ILEN-1:0]   word_o,
  output logic                         redirect_o
);

  import fetch_pkg::*;

  logic            rst_load_q;
  logic [VLEN-1:0] npc_d, npc_q;
  logic [VLEN-1:0] fetch_addr;
  logic            outstanding_q;
  logic            word_valid_q;
  logic            is_mispredict;
  logic            kill;
  logic            room;
  logic            accept;

  // ------------------------------
  // redirects
  // ------------------------------
  assign is_mispredict = resolved_i.valid & resolved_i.mispredict;
  // external sources also empty the queue
  assign redirect_o    = is_mispredict | eret_i | ex_valid_i | flush_i;
  // a predicted taken word only drops what follows it
  assign kill          = redirect_o | pred_i.taken;

  // need a slot for the new word plus the registered one
  assign room   = queue_space_i > QCNT_W'(word_valid_q);
  assign accept = imem_req_o.req & imem_rsp_i.ready;

  // first cycle out of reset fetches from the boot address
  assign fetch_addr = rst_load_q ? boot_addr_i : npc_q;

  assign imem_req_o.req   = ~outstanding_q & ~kill & room;
  assign imem_req_o.kill  = kill;
  assign imem_req_o.vaddr = fetch_addr;

  // lowest to highest priority, later assignment wins
  always_comb begin
    npc_d = fetch_addr;
    if (accept) begin
      npc_d = fetch_addr + VLEN'(INSTR_BYTES);
    end
    if (pred_i.taken) begin
      npc_d = pred_i.target;
    end
    if (is_mispredict) begin
      npc_d = resolved_i.target;
    end
    if (eret_i) begin
      npc_d = epc_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_base_i;
    end
  end

  // ------------------------------
  // state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_load_q    <= 1'b1;
      npc_q         <= '0;
      outstanding_q <= 1'b0;
      word_valid_q  <= 1'b0;
    end else begin
      rst_load_q <= 1'b0;
      npc_q      <= npc_d;
      // kill drops the request in flight
      if (kill || imem_rsp_i.valid) begin
        outstanding_q <= 1'b0;
      end else if (accept) begin
        outstanding_q <= 1'b1;
      end
      // a response arriving with kill belongs to the old path
      word_valid_q <= imem_rsp_i.valid & ~kill;
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (imem_rsp_i.valid) begin
      word_pc_o <= imem_rsp_i.vaddr;
      word_o    <= imem_rsp_i.data;
    end
  end

  assign word_valid_o = word_valid_q;

endmodule

// File: verilog/ras.sv
`timescale 1ns/10ps

module ras (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  logic                       pop_i,
  input  logic [fetch_pkg::VLEN-1:0] data_i,
  output fetch_pkg::ras_entry_t      top_o
);

  import fetch_pkg::*;

  // entry 0 is the top of the stack
  logic [RAS_DEPTH-1:0] valid_q;
  logic [VLEN-1:0]      addr_q [RAS_DEPTH];

  assign top_o.valid = valid_q[0];
  assign top_o.addr  = addr_q[0];

  // valid bits, the only state that needs reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (push_i && pop_i) begin
      // return followed by call, top gets overwritten
      valid_q[0] <= 1'b1;
    end else if (push_i) begin
      // shift down, deepest entry falls off
      for (int i = RAS_DEPTH - 1; i > 0; i--) begin
        valid_q[i] <= valid_q[i-1];
      end
      valid_q[0] <= 1'b1;
    end else if (pop_i) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        valid_q[i] <= valid_q[i+1];
      end
      valid_q[RAS_DEPTH-1] <= 1'b0;
    end
  end

  // return addresses follow the same shifts
  always_ff @(posedge clk_i) begin
    if (push_i && pop_i) begin
      addr_q[0] <= data_i;
    end else if (push_i) begin
      for (int i = RAS_DEPTH - 1; i > 0; i--) begin
        addr_q[i] <= addr_q[i-1];
      end
      addr_q[0] <= data_i;
    end else if (pop_i) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        addr_q[i] <= addr_q[i+1];
      end
    end
  end

endmodule
